//--- periph_pkg.sv
`default_nettype none

package periph_pkg;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    localparam logic [31:0] ADDR_END    = 32'h8000_0000;  // End-of-program marker
    localparam logic [31:0] ADDR_UART_A = 32'h8000_4000;  // Character output
    localparam logic [31:0] ADDR_UART_B = 32'h8000_1000;  // Character output alias
    localparam logic [31:0] ADDR_STATUS = 32'h8000_6000;  // Read-only status word

    // Bit positions inside the status word
    localparam int STAT_EMPTY_BIT = 0;  // TX FIFO empty
    localparam int STAT_FULL_BIT  = 1;  // TX FIFO full
    localparam int STAT_IRQ_BIT   = 2;  // External interrupt pending
    localparam int STAT_BUSY_BIT  = 3;  // Transmitter active

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // GPIO event codes
    typedef enum logic [7:0] {
        EVT_NONE = 8'h00,
        EVT_END  = 8'h80,
        EVT_CHAR = 8'h84
    } evt_code_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    // Core data port request of 69 bits
    typedef struct packed {
        logic        enable;  // Request valid
        logic [3:0]  wstrb;   // Zero means read
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // One-cycle GPIO event
    typedef struct packed {
        evt_code_e  code;
        logic [7:0] data;
    } gpio_evt_t;

endpackage

`default_nettype wire

//--- btn_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

module btn_debouncer #(
    parameter int DEBNC_CLOCKS = 65536
) (
    input  wire  clk,
    input  wire  reset,
    input  logic btn_i,
    output logic btn_o
);

    localparam int CNT_W = $clog2(DEBNC_CLOCKS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBNC_CLOCKS - 1);

    logic             sync1_q;  // First synchronizer stage
    logic             sync2_q;  // Second stage output
    logic [CNT_W-1:0] cnt_q;    // Consecutive differing cycles

    // Two-flop synchronizer for the asynchronous button
    always_ff @(posedge clk) begin
        if (reset) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
        end else begin
            sync1_q <= btn_i;
            sync2_q <= sync1_q;
        end
    end

    // Stability counter
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q <= '0;
            btn_o <= 1'b0;
        end else if (sync2_q == btn_o) begin
            cnt_q <= '0;                 // Bounce back restarts the count
        end else if (cnt_q == CNT_LAST) begin
            cnt_q <= '0;
            btn_o <= sync2_q;            // Adopt the stable level
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- uart_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire        clk,
    input  wire        reset,
    input  logic       push_i,
    input  logic [7:0] push_data_i,
    input  logic       pop_i,
    output logic [7:0] pop_data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;  // Extra wrap bit

    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;   // Never overwrite
    assign do_pop  = pop_i && !empty_o;   // Never underflow

    // Pointer comparison for the flags
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                     (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

    // First-word fall-through read
    assign pop_data_o = mem[rd_ptr_q[ADDR_W-1:0]];

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);  // Independent of push
            end
        end
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import periph_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire        clk,
    input  wire        reset,
    input  logic       send_i,
    input  logic [7:0] send_data_i,
    output logic       ready_o,
    output logic       busy_o,
    output logic       uart_tx_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    uart_state_e      state_q;
    logic [CNT_W-1:0] bit_cnt_q;   // Cycles within current bit
    logic [2:0]       bit_idx_q;   // Data bit being sent
    logic [7:0]       shift_q;     // Byte being shifted out
    logic             bit_done;

    assign bit_done = (bit_cnt_q == BIT_LAST);

    // Idle and no byte coming in this cycle
    assign ready_o = (state_q == UART_IDLE) && !send_i;
    assign busy_o  = !ready_o;

    //////////////////////////////////////////////////
    // Transmitter FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= UART_IDLE;
            bit_cnt_q <= '0;
            bit_idx_q <= '0;
            uart_tx_o <= 1'b1;                // Line idles high
        end else begin
            case (state_q)
                UART_IDLE: begin
                    bit_cnt_q <= '0;
                    uart_tx_o <= 1'b1;
                    if (send_i) begin
                        state_q   <= UART_START;
                        uart_tx_o <= 1'b0;    // Start bit
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        state_q   <= UART_DATA;
                        bit_cnt_q <= '0;
                        bit_idx_q <= '0;
                        uart_tx_o <= shift_q[0];  // LSB first
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        bit_cnt_q <= '0;
                        if (bit_idx_q == 3'd7) begin
                            state_q   <= UART_STOP;
                            uart_tx_o <= 1'b1;    // Stop bit
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            uart_tx_o <= shift_q[1];
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (bit_done) begin
                        state_q   <= UART_IDLE;
                        bit_cnt_q <= '0;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                default: state_q <= UART_IDLE;
            endcase
        end
    end

    // Data shifter
    always_ff @(posedge clk) begin
        if (state_q == UART_IDLE && send_i) begin
            shift_q <= send_data_i;               // Latch byte on accept
        end else if (state_q == UART_DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[7:1]};      // Next bit into [0]
        end
    end

endmodule

`default_nettype wire

//--- periph_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module periph_ctrl
    import periph_pkg::*;
(
    input  wire         clk,
    input  wire         reset,

    input  bus_req_t    req_i,
    output logic [31:0] data_o,
    output logic        stall_o,

    output gpio_evt_t   gpio_evt_o,

    output logic        push_o,
    output logic [7:0]  push_data_o,
    input  logic        fifo_full_i,
    input  logic        fifo_empty_i,
    input  logic        uart_busy_i,

    input  logic        btn_i,
    output logic        mei_o,
    input  logic        irq_ack_i
);

    logic        is_write;     // Enable with any strobe
    logic        is_read;      // Enable with no strobe
    logic        char_hit;
    logic        end_hit;
    logic        status_hit;
    logic        char_write;
    logic        status_read;
    logic        stall_r;      // Stall seen last cycle
    gpio_evt_t   evt_d;
    logic [31:0] status_word;
    logic        btn_r;
    logic        btn_rise;
    logic        irq_req_q;    // Pending button request

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    assign is_write = req_i.enable && (req_i.wstrb != 4'b0000);
    assign is_read  = req_i.enable && (req_i.wstrb == 4'b0000);

    assign char_hit   = (req_i.addr == ADDR_UART_A) || (req_i.addr == ADDR_UART_B);
    assign end_hit    = (req_i.addr == ADDR_END);
    assign status_hit = (req_i.addr == ADDR_STATUS);

    assign char_write  = is_write && char_hit;
    assign status_read = is_read && status_hit;

    // FIFO push in the acceptance cycle
    assign push_o      = char_write && !fifo_full_i;
    assign push_data_o = req_i.wdata[7:0];   // Low byte only

    //////////////////////////////////////////////////
    // Stall generation
    //////////////////////////////////////////////////

    // Full FIFO holds the write and a status read stalls once
    assign stall_o = (char_write && fifo_full_i) || (status_read && !stall_r);

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_r <= 1'b0;
        end else begin
            stall_r <= stall_o;
        end
    end

    //////////////////////////////////////////////////
    // GPIO event
    //////////////////////////////////////////////////

    always_comb begin
        evt_d.code = EVT_NONE;
        evt_d.data = 8'h00;
        if (push_o) begin
            evt_d.code = EVT_CHAR;           // Accepted character
            evt_d.data = req_i.wdata[7:0];
        end else if (is_write && end_hit) begin
            evt_d.code = EVT_END;            // Data stays zero
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_evt_o <= '{code: EVT_NONE, data: 8'h00};
        end else begin
            gpio_evt_o <= evt_d;             // One cycle after acceptance
        end
    end

    //////////////////////////////////////////////////
    // Status read
    //////////////////////////////////////////////////

    always_comb begin
        status_word                 = '0;
        status_word[STAT_EMPTY_BIT] = fifo_empty_i;
        status_word[STAT_FULL_BIT]  = fifo_full_i;
        status_word[STAT_IRQ_BIT]   = mei_o;
        status_word[STAT_BUSY_BIT]  = uart_busy_i;
    end

    // Sampled in the stall cycle and zero otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            data_o <= '0;
        end else if (status_read && !stall_r) begin
            data_o <= status_word;
        end else begin
            data_o <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Button interrupt
    //////////////////////////////////////////////////

    assign btn_rise = btn_i && !btn_r;   // Debounced rising edge

    always_ff @(posedge clk) begin
        if (reset) begin
            btn_r     <= 1'b0;
            irq_req_q <= 1'b0;
            mei_o     <= 1'b0;
        end else begin
            btn_r <= btn_i;
            if (mei_o && irq_ack_i) begin
                irq_req_q <= 1'b0;           // Edge in this cycle is dropped
                mei_o     <= 1'b0;
            end else begin
                if (btn_rise) begin
                    irq_req_q <= 1'b1;
                end
                if (irq_req_q) begin
                    mei_o <= 1'b1;           // Two cycles after the level rises
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top
    import periph_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868,
    parameter int DEBNC_CLOCKS = 65536,
    parameter int FIFO_DEPTH   = 16
) (
    input  wire         clk,
    input  wire         reset,
    input  bus_req_t    req_i,
    output logic [31:0] data_o,
    output logic        stall_o,
    output gpio_evt_t   gpio_evt_o,
    input  logic        btn_i,
    output logic        uart_tx_o,
    output logic        mei_o,
    input  logic        irq_ack_i
);

    logic       btn_clean;
    logic       fifo_push;
    logic [7:0] fifo_push_data;
    logic       fifo_pop;
    logic [7:0] fifo_pop_data;
    logic       fifo_full;
    logic       fifo_empty;
    logic       uart_ready;
    logic       uart_busy;
    logic       send_q;        // Send pulse one cycle after the pop
    logic [7:0] send_byte_q;   // Byte captured at pop

    btn_debouncer #(
        .DEBNC_CLOCKS(DEBNC_CLOCKS)
    ) u_debouncer (
        .clk  (clk),
        .reset(reset),
        .btn_i(btn_i),
        .btn_o(btn_clean)
    );

    periph_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req_i),
        .data_o      (data_o),
        .stall_o     (stall_o),
        .gpio_evt_o  (gpio_evt_o),
        .push_o      (fifo_push),
        .push_data_o (fifo_push_data),
        .fifo_full_i (fifo_full),
        .fifo_empty_i(fifo_empty),
        .uart_busy_i (uart_busy),
        .btn_i       (btn_clean),
        .mei_o       (mei_o),
        .irq_ack_i   (irq_ack_i)
    );

    uart_tx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_i     (fifo_push),
        .push_data_i(fifo_push_data),
        .pop_i      (fifo_pop),
        .pop_data_o (fifo_pop_data),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty)
    );

    //////////////////////////////////////////////////
    // FIFO to transmitter handoff
    //////////////////////////////////////////////////

    // One byte in flight at a time
    assign fifo_pop = uart_ready && !fifo_empty && !send_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            send_q <= 1'b0;
        end else begin
            send_q <= fifo_pop;
        end
    end

    // Read pointer moves on pop, so keep the head byte
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            send_byte_q <= fifo_pop_data;
        end
    end

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .send_i     (send_q),
        .send_data_i(send_byte_q),
        .ready_o    (uart_ready),
        .busy_o     (uart_busy),
        .uart_tx_o  (uart_tx_o)
    );

endmodule

`default_nettype wire

//--- tb_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph
    import periph_pkg::*;
();

    localparam int CLKS_PER_BIT = 8;
    localparam int DEBNC_CLOCKS = 16;
    localparam int FIFO_DEPTH   = 4;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;     // Mid-bit sample point
    localparam int STALL_LIMIT  = 40 * CLKS_PER_BIT;
    localparam int DRAIN_LIMIT  = 20 * 12 * CLKS_PER_BIT;
    localparam int MEI_LIMIT    = 4 * DEBNC_CLOCKS + 20;
    localparam bus_req_t IDLE_REQ = '0;

    logic        clk;
    logic        reset;
    bus_req_t    req;
    logic [31:0] data_o;
    logic        stall_o;
    gpio_evt_t   gpio_evt_o;
    logic        btn_i;
    logic        uart_tx_o;
    logic        mei_o;
    logic        irq_ack_i;

    int          seed = 71;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    string       test_name = "reset";
    logic [7:0]  exp_q[$];            // Accepted bytes in order
    int          n_accepted = 0;
    int          n_started = 0;       // Start bits seen on the line
    int          n_stall = 0;         // Stalled character writes
    gpio_evt_t   exp_evt;
    logic [31:0] stat_exp;
    logic        stat_pending;        // Status data due this cycle
    logic        rx_busy;
    int          rx_t;
    int          bit_n;
    logic [7:0]  rx_shift;
    logic        wr_req;
    logic        rd_req;
    logic        char_wr;
    logic        stat_rd;

    periph_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .DEBNC_CLOCKS(DEBNC_CLOCKS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .req_i     (req),
        .data_o    (data_o),
        .stall_o   (stall_o),
        .gpio_evt_o(gpio_evt_o),
        .btn_i     (btn_i),
        .uart_tx_o (uart_tx_o),
        .mei_o     (mei_o),
        .irq_ack_i (irq_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    // Request decode from the address map
    assign wr_req  = req.enable && (req.wstrb != 4'b0000);
    assign rd_req  = req.enable && (req.wstrb == 4'b0000);
    assign char_wr = wr_req && (req.addr == ADDR_UART_A || req.addr == ADDR_UART_B);
    assign stat_rd = rd_req && (req.addr == ADDR_STATUS);

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("CHECK FAILED %s / %s: expected %0h, actual %0h",
                     test_name, what, exp, act);
        end
    endtask

    task automatic note_error(input string msg);
        err_cnt++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Status bits from model occupancy, line activity and interrupt level
    function automatic logic [31:0] predict_status(input int occ, input logic busy,
                                                   input logic irq);
        logic [31:0] w;
        w                 = '0;
        w[STAT_EMPTY_BIT] = (occ == 0);
        w[STAT_FULL_BIT]  = (occ == FIFO_DEPTH);
        w[STAT_IRQ_BIT]   = irq;
        w[STAT_BUSY_BIT]  = busy;
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Bus model and checks
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            exp_evt      = '{code: EVT_NONE, data: 8'h00};
            stat_pending = 1'b0;
        end else begin
            check_val("gpio event", exp_evt, gpio_evt_o);     // One cycle after acceptance
            check_val("data_o", stat_pending ? stat_exp : 32'd0, data_o);
            exp_evt = '{code: EVT_NONE, data: 8'h00};
            if (char_wr && !stall_o) begin
                exp_evt = '{code: EVT_CHAR, data: req.wdata[7:0]};
                exp_q.push_back(req.wdata[7:0]);
                n_accepted++;
            end else if (wr_req && req.addr == ADDR_END) begin
                exp_evt = '{code: EVT_END, data: 8'h00};
            end
            if (char_wr && stall_o) begin
                n_stall++;
            end
            if (stat_pending) begin
                check_val("stall after status", 32'd0, stall_o);
                stat_pending = 1'b0;
            end else if (stat_rd) begin
                check_val("status stall", 32'd1, stall_o);
                stat_exp     = predict_status(n_accepted - n_started, rx_busy, mei_o);
                stat_pending = 1'b1;
            end else if (rd_req) begin
                check_val("other read stall", 32'd0, stall_o);  // Never stalls
            end
        end
    end

    stall_cause_a: assert property (@(posedge clk) disable iff (reset)
        stall_o |-> (char_wr || stat_rd))
        else note_error("stall_o high without a character write or status read");

    status_once_a: assert property (@(posedge clk) disable iff (reset)
        (stat_rd && stall_o) |=> !stall_o)
        else note_error("status read stalled for more than one cycle");

    mei_clear_a: assert property (@(posedge clk) disable iff (reset)
        (mei_o && irq_ack_i) |=> !mei_o)
        else note_error("mei_o did not clear after acknowledge");

    //////////////////////////////////////////////////
    // UART frame decoder
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            rx_busy <= 1'b0;
            rx_t    = 0;
        end else if (!rx_busy) begin
            if (uart_tx_o == 1'b0) begin              // Falling edge of start bit
                rx_busy   <= 1'b1;
                rx_t      = 0;
                n_started <= n_started + 1;
            end
        end else begin
            rx_t++;
            if (rx_t >= HALF_BIT && (rx_t - HALF_BIT) % CLKS_PER_BIT == 0) begin
                bit_n = (rx_t - HALF_BIT) / CLKS_PER_BIT;
                if (bit_n == 0) begin
                    check_val("start bit", 32'd0, uart_tx_o);
                end else if (bit_n <= 8) begin
                    rx_shift[bit_n-1] = uart_tx_o;    // LSB first
                end else begin
                    check_val("stop bit", 32'd1, uart_tx_o);
                    if (exp_q.size() == 0) begin
                        note_error("UART frame received with no accepted byte outstanding");
                    end else begin
                        check_val("uart byte", exp_q.pop_front(), rx_shift);
                    end
                    rx_busy <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Hold the request until the first cycle with stall_o low
    task automatic bus_access(input logic [31:0] addr, input logic [3:0] wstrb,
                              input logic [31:0] wdata);
        int waited;
        waited = 0;
        req <= '{enable: 1'b1, wstrb: wstrb, addr: addr, wdata: wdata};
        @(posedge clk);
        while (stall_o) begin
            if (waited == STALL_LIMIT) begin
                note_error("timeout, stall_o never released");
                end_run();
            end
            waited++;
            @(posedge clk);
        end
        req <= IDLE_REQ;
    endtask

    task automatic char_write();
        bus_access(($random(seed) & 1) ? ADDR_UART_A : ADDR_UART_B, 4'hf, $random(seed));
    endtask

    task automatic drain_uart();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || rx_busy) begin
            if (waited == DRAIN_LIMIT) begin
                note_error("timeout, accepted bytes never left the UART");
                end_run();
            end
            waited++;
            @(posedge clk);
        end
        repeat (2 * CLKS_PER_BIT) @(posedge clk);     // Stop bit tail
        check_val("idle line", 32'd1, uart_tx_o);
    endtask

    task automatic wait_mei();
        int waited;
        waited = 0;
        while (mei_o !== 1'b1) begin
            if (waited == MEI_LIMIT) begin
                note_error("timeout, mei_o never rose after a stable press");
                end_run();
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic ack_irq();
        irq_ack_i <= 1'b1;
        @(posedge clk);
        irq_ack_i <= 1'b0;
        @(posedge clk);
        check_val("mei_o after ack", 32'd0, mei_o);
    endtask

    task automatic hold_mei(input logic level, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_val("mei_o level", level, mei_o);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        req       = IDLE_REQ;
        btn_i     = 1'b0;
        irq_ack_i = 1'b0;
        reset     = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_val("uart_tx_o", 32'd1, uart_tx_o);
        check_val("mei_o", 32'd0, mei_o);
        check_val("stall_o", 32'd0, stall_o);
        check_val("data_o", 32'd0, data_o);
        check_val("gpio event", 32'd0, gpio_evt_o);

        test_name = "char_writes";
        for (int i = 0; i < 8; i++) begin
            char_write();
            repeat ($unsigned($random(seed)) % 4) @(posedge clk);   // Random gap
        end
        drain_uart();

        test_name = "back_pressure";
        for (int i = 0; i < 3 * FIFO_DEPTH; i++) begin
            char_write();                             // Back to back
        end
        if (n_stall == 0) begin
            note_error("burst longer than the FIFO never stalled");
        end
        repeat (10) @(posedge clk);
        bus_access(ADDR_STATUS, 4'b0000, 32'h0);      // Expect full and busy
        drain_uart();

        test_name = "end_other";
        begin
            int started_before;
            started_before = n_started;
            bus_access(ADDR_END, 4'hf, $random(seed));
            bus_access(32'h8000_2000, 4'hf, $random(seed));   // Unmapped
            bus_access(ADDR_UART_A, 4'b0000, 32'h0);          // Read of a character address
            repeat (12 * CLKS_PER_BIT) @(posedge clk);
            check_val("frames started", started_before, n_started);
        end

        test_name = "status";
        bus_access(ADDR_STATUS, 4'b0000, 32'h0);      // Quiescent
        char_write();
        char_write();
        repeat (10) @(posedge clk);
        bus_access(ADDR_STATUS, 4'b0000, 32'h0);      // One byte queued
        bus_access(ADDR_UART_B, 4'b0000, 32'h0);
        bus_access(32'h1234_0000, 4'b0000, 32'h0);
        drain_uart();

        test_name = "button";
        for (int p = 0; p < 4; p++) begin
            btn_i <= 1'b1;                            // Glitch too short
            hold_mei(1'b0, DEBNC_CLOCKS / 2);
            btn_i <= 1'b0;
            hold_mei(1'b0, 6);
        end
        hold_mei(1'b0, 2 * DEBNC_CLOCKS);
        btn_i <= 1'b1;
        wait_mei();
        hold_mei(1'b1, 40);                           // Stays pending without ack
        bus_access(ADDR_STATUS, 4'b0000, 32'h0);
        ack_irq();
        hold_mei(1'b0, 40);                           // Still pressed so no new edge
        btn_i <= 1'b0;
        hold_mei(1'b0, 3 * DEBNC_CLOCKS);
        btn_i <= 1'b1;
        wait_mei();
        ack_irq();
        hold_mei(1'b0, 10);

        end_run();
    end

endmodule

`default_nettype wire

//--- verilog.f
periph_pkg.sv
btn_debouncer.sv
uart_tx_fifo.sv
uart_tx.sv
periph_ctrl.sv
periph_top.sv
tb_periph.sv
